// File: design/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define XLEN 32

`define OP_ALU    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_SYSTEM 7'b1110011

`define F3_PRIV   4'h0
`define F3_CSRRW  4'h1
`define F3_CSRRS  4'h2
`define F3_CSRRC  4'h3
`define F3_CSRRWI 4'h5
`define F3_CSRRSI 4'h6
`define F3_CSRRCI 4'h7

`define F12_ECALL  12'h000
`define F12_EBREAK 12'h001
`define F12_MRET   12'h302

`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_SLL  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_SLT  4'd8
`define ALU_SLTU 4'd9
`define ALU_SGE  4'd10
`define ALU_SGEU 4'd11

`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

`define CAUSE_ECALL_M 32'd11

`define MEM_WORDS   256
`define MEM_LATENCY 2

`endif

// File: design/exec_pkg.sv
`include "exec_consts.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       reg_idx_t;
  typedef logic [11:0]      csr_addr_t;
  typedef logic [3:0]       alu_op_t;
  typedef logic [6:0]       opcode_t;

  typedef enum logic {
    EXU_IDLE,
    EXU_WAIT_READY  // Covers both the memory wait and the result hold.
  } exu_state_t;

  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_t;

endpackage

// File: design/mem_bus_if.sv
interface mem_bus_if
  import exec_pkg::*;
();
  logic  req;     // Level, held until the response pulse.
  logic  we;
  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  rvalid;  // One-cycle pulse that ends a load.
  logic  wready;  // One-cycle pulse that ends a store.

  modport exu (
    output req, we, addr, wdata,
    input  rdata, rvalid, wready
  );

  modport mem (
    input  req, we, addr, wdata,
    output rdata, rvalid, wready
  );
endinterface

// File: design/alu.sv
`include "exec_consts.svh"

module alu
  import exec_pkg::*;
(
  input  word_t   src1_i,
  input  word_t   src2_i,
  input  alu_op_t op_i,
  output word_t   res_o
);
  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;

  always_comb begin
    case (op_i)
      `ALU_ADD:  res_o = src1_i + src2_i;
      `ALU_SUB:  res_o = src1_i - src2_i;
      `ALU_AND:  res_o = src1_i & src2_i;
      `ALU_OR:   res_o = src1_i | src2_i;
      `ALU_XOR:  res_o = src1_i ^ src2_i;
      `ALU_SLL:  res_o = src1_i << shamt;
      `ALU_SRL:  res_o = src1_i >> shamt;
      `ALU_SRA:  res_o = word_t'($signed(src1_i) >>> shamt);
      `ALU_SLT:  res_o = word_t'(lt_s);
      `ALU_SLTU: res_o = word_t'(lt_u);
      `ALU_SGE:  res_o = word_t'(!lt_s);  // Used by bge.
      `ALU_SGEU: res_o = word_t'(!lt_u);
      default:   res_o = '0;
    endcase
  end

endmodule

// File: design/csr_file.sv
`include "exec_consts.svh"

module csr_file
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  csr_addr_t raddr_i,
  input  logic      we_i,
  input  csr_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      ecall_i,
  input  logic      mret_i,
  input  word_t     epc_i,
  output word_t     rdata_o,
  output word_t     mtvec_o,
  output word_t     mepc_o
);
  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_comb begin
    case (raddr_i)
      `CSR_MSTATUS: rdata_o = mstatus;
      `CSR_MTVEC:   rdata_o = mtvec;
      `CSR_MEPC:    rdata_o = mepc;
      `CSR_MCAUSE:  rdata_o = mcause;
      default:      rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          `CSR_MSTATUS: mstatus <= wdata_i;
          `CSR_MTVEC:   mtvec   <= wdata_i;
          `CSR_MEPC:    mepc    <= wdata_i;
          `CSR_MCAUSE:  mcause  <= wdata_i;
          default: begin
          end
        endcase
      end
      if (ecall_i) begin
        mepc   <= epc_i;
        mcause <= `CAUSE_ECALL_M;  // Environment call from M-mode.
      end
      if (mret_i) begin
        mstatus[3] <= mstatus[7];  // MIE takes MPIE.
        mstatus[7] <= 1'b1;
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

  // The controller decodes one privileged instruction at a time.
  a_trap_onehot: assert property (@(posedge clk) disable iff (rst) !(ecall_i && mret_i))
    else $error("csr_file: ecall and mret requested together");

endmodule

// File: design/data_mem.sv
`include "exec_consts.svh"

module data_mem
  import exec_pkg::*;
(
  input logic    clk,
  input logic    rst,
  mem_bus_if.mem bus
);
  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
  localparam int IDX_W = $clog2(`MEM_WORDS);

  mem_state_t       state;
  logic [CNT_W-1:0] cnt;
  logic             accept;
  logic             last;
  logic             we_q;
  logic [IDX_W-1:0] idx_q;
  word_t            wdata_q;
  word_t            mem [`MEM_WORDS];

  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // A request still high during the response pulse is the one just served.
  assign accept = (state == MEM_IDLE) && bus.req && !bus.rvalid && !bus.wready;
  assign last   = (state == MEM_BUSY) && (cnt == CNT_W'(`MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= MEM_IDLE;
      cnt        <= '0;
      bus.rvalid <= 1'b0;
      bus.wready <= 1'b0;
    end else begin
      bus.rvalid <= 1'b0;
      bus.wready <= 1'b0;
      if (accept) begin
        state <= MEM_BUSY;
        cnt   <= '0;
      end else if (last) begin
        state      <= MEM_IDLE;
        bus.rvalid <= !we_q;
        bus.wready <= we_q;
      end else if (state == MEM_BUSY) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_q    <= bus.we;
      idx_q   <= bus.addr[IDX_W+1:2];  // Word index.
      wdata_q <= bus.wdata;
    end
    if (last) begin
      if (we_q) begin
        mem[idx_q] <= wdata_q;
      end else begin
        bus.rdata <= mem[idx_q];
      end
    end
  end

  // A response pulse answers the outstanding request, one kind at a time.
  a_one_resp: assert property (@(posedge clk) disable iff (rst)
    (bus.rvalid || bus.wready) |->
      bus.req && (bus.rvalid != bus.wready) && (bus.wready == bus.we))
    else $error("data_mem: response pulse does not match the request");

endmodule

// File: design/exu.sv
`include "exec_consts.svh"

module exu
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     prev_valid_i,
  input  logic     next_ready_i,
  input  opcode_t  opcode_i,
  input  alu_op_t  alu_op_i,
  input  word_t    op1_i,
  input  word_t    op2_i,
  input  word_t    opj_i,
  input  word_t    imm_i,
  input  word_t    pc_i,
  input  reg_idx_t rd_i,
  input  logic     rwen_i,
  output logic     ready_o,
  output logic     valid_o,
  output word_t    reg_wdata_o,
  output word_t    npc_o,
  output reg_idx_t rd_o,
  output logic     rwen_o,
  output logic     wben_o,
  output logic     ebreak_o,
  mem_bus_if.exu   bus
);
  exu_state_t state;
  opcode_t    opcode_q;
  alu_op_t    alu_op_q;
  word_t      op1_q;
  word_t      op2_q;
  word_t      imm_q;
  word_t      pc_q;
  word_t      target_q;
  word_t      load_q;
  logic       req_q;
  logic       fire;
  logic       is_mem_in;
  logic       mem_done;
  logic       valid_set;
  logic       commit;
  logic       is_system;
  logic       is_priv;
  logic       csr_we;
  csr_addr_t  csr_addr;
  word_t      csr_src;
  word_t      csr_wdata;
  word_t      csr_rdata;
  word_t      mtvec;
  word_t      mepc;
  word_t      alu_res;
  word_t      pc_plus4;

  assign ready_o   = (state == EXU_IDLE);
  assign fire      = prev_valid_i && ready_o;
  assign is_mem_in = (opcode_i == `OP_LOAD) || (opcode_i == `OP_STORE);
  assign mem_done  = req_q && (bus.rvalid || bus.wready);
  assign valid_set = (fire && !is_mem_in) || mem_done;
  assign commit    = valid_o && next_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= EXU_IDLE;
      valid_o <= 1'b0;
      wben_o  <= 1'b0;
      req_q   <= 1'b0;
    end else begin
      wben_o <= valid_set;  // High only in the first cycle of valid_o.
      if (fire) begin
        state <= EXU_WAIT_READY;
        req_q <= is_mem_in;
      end else if (commit) begin
        state <= EXU_IDLE;
      end
      if (mem_done) begin
        req_q <= 1'b0;
      end
      if (valid_set) begin
        valid_o <= 1'b1;
      end else if (commit) begin
        valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      opcode_q <= opcode_i;
      alu_op_q <= alu_op_i;
      op1_q    <= op1_i;
      op2_q    <= op2_i;
      imm_q    <= imm_i;
      pc_q     <= pc_i;
      target_q <= opj_i + imm_i;
      rd_o     <= rd_i;
      rwen_o   <= rwen_i;
    end
    if (req_q && bus.rvalid) begin
      load_q <= bus.rdata;
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = (opcode_q == `OP_STORE);
  assign bus.addr  = target_q;
  assign bus.wdata = op2_q;

  alu alu0 (
    .src1_i (op1_q),
    .src2_i (op2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  assign is_system = (opcode_q == `OP_SYSTEM);
  assign is_priv   = is_system && (imm_q[3:0] == `F3_PRIV);
  assign csr_addr  = imm_q[15:4];
  assign pc_plus4  = pc_q + 32'd4;
  assign ebreak_o  = valid_o && is_priv && (imm_q[15:4] == `F12_EBREAK);

  // For the immediate forms the decoder passes the 5-bit zimm in op1.
  assign csr_src = (imm_q[3:0] inside {`F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI})
                 ? word_t'(op1_q[4:0]) : op1_q;

  always_comb begin
    csr_we    = 1'b1;
    csr_wdata = csr_src;
    case (imm_q[3:0])
      `F3_CSRRW, `F3_CSRRWI: csr_wdata = csr_src;
      `F3_CSRRS, `F3_CSRRSI: csr_wdata = csr_rdata | csr_src;
      `F3_CSRRC, `F3_CSRRCI: csr_wdata = csr_rdata & ~csr_src;
      default: csr_we = 1'b0;
    endcase
  end

  csr_file csr0 (
    .clk     (clk),
    .rst     (rst),
    .raddr_i (csr_addr),
    .we_i    (commit && is_system && csr_we),
    .waddr_i (csr_addr),
    .wdata_i (csr_wdata),
    .ecall_i (commit && is_priv && (imm_q[15:4] == `F12_ECALL)),
    .mret_i  (commit && is_priv && (imm_q[15:4] == `F12_MRET)),
    .epc_i   (pc_q),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  always_comb begin
    case (opcode_q)
      `OP_LOAD:            reg_wdata_o = load_q;
      `OP_SYSTEM:          reg_wdata_o = csr_rdata;  // Old value, written back on commit.
      `OP_JAL, `OP_JALR:   reg_wdata_o = pc_plus4;
      default:             reg_wdata_o = alu_res;
    endcase
  end

  always_comb begin
    npc_o = pc_plus4;
    case (opcode_q)
      `OP_JAL, `OP_JALR: npc_o = target_q;
      `OP_BRANCH: begin
        case (alu_op_q)
          `ALU_SUB:  npc_o = (alu_res == '0) ? target_q : pc_plus4;
          `ALU_XOR:  npc_o = (alu_res != '0) ? target_q : pc_plus4;
          `ALU_SLT, `ALU_SLTU, `ALU_SGE, `ALU_SGEU:
                     npc_o = alu_res[0] ? target_q : pc_plus4;
          default:   npc_o = pc_plus4;
        endcase
      end
      `OP_SYSTEM: begin
        if (is_priv && (imm_q[15:4] == `F12_ECALL)) begin
          npc_o = mtvec;
        end else if (is_priv && (imm_q[15:4] == `F12_MRET)) begin
          npc_o = mepc;
        end
      end
      default: npc_o = pc_plus4;
    endcase
  end

  // A result offered downstream is held until it is taken.
  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(reg_wdata_o) && $stable(npc_o))
    else $error("exu: result changed under back-pressure");

endmodule

// File: design/exec_top.sv
module exec_top
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     prev_valid_i,
  input  logic     next_ready_i,
  input  opcode_t  opcode_i,
  input  alu_op_t  alu_op_i,
  input  word_t    op1_i,
  input  word_t    op2_i,
  input  word_t    opj_i,
  input  word_t    imm_i,
  input  word_t    pc_i,
  input  reg_idx_t rd_i,
  input  logic     rwen_i,
  output logic     ready_o,
  output logic     valid_o,
  output word_t    reg_wdata_o,
  output word_t    npc_o,
  output reg_idx_t rd_o,
  output logic     rwen_o,
  output logic     wben_o,
  output logic     ebreak_o
);
  mem_bus_if bus0 ();

  exu exu0 (
    .clk          (clk),
    .rst          (rst),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .opcode_i     (opcode_i),
    .alu_op_i     (alu_op_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .rd_i         (rd_i),
    .rwen_i       (rwen_i),
    .ready_o      (ready_o),
    .valid_o      (valid_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .rd_o         (rd_o),
    .rwen_o       (rwen_o),
    .wben_o       (wben_o),
    .ebreak_o     (ebreak_o),
    .bus          (bus0)
  );

  data_mem mem0 (
    .clk (clk),
    .rst (rst),
    .bus (bus0)
  );

endmodule

// File: bench/tb_clock.sv
module tb_clock (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #2 rst_o = 1'b0;
  end
endmodule

// File: bench/exec_tb.sv
`include "exec_consts.svh"

module exec_tb
  import exec_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic     clk;
  logic     rst;
  logic     prev_valid;
  logic     next_ready;
  opcode_t  opcode;
  alu_op_t  alu_op;
  word_t    op1;
  word_t    op2;
  word_t    opj;
  word_t    imm;
  word_t    pc;
  reg_idx_t rd;
  logic     rwen;
  logic     ready;
  logic     valid;
  word_t    reg_wdata;
  word_t    npc;
  reg_idx_t rd_out;
  logic     rwen_out;
  logic     wben;
  logic     ebreak;

  int          errors;
  int          issued;
  int          cycles;
  logic [31:0] rng;
  reg_idx_t    cur_rd;
  logic        cur_rwen;
  word_t       res_wdata;
  word_t       res_npc;
  logic        res_ebreak;
  reg_idx_t    res_rd;
  logic        res_rwen;
  int          res_lat;
  word_t       m_mstatus;
  word_t       m_mtvec;
  word_t       m_mepc;
  word_t       m_mcause;
  word_t       model_mem [`MEM_WORDS];

  tb_clock clk0 (.clk_o(clk), .rst_o(rst));

  exec_top dut0 (
    .clk (clk), .rst (rst), .prev_valid_i (prev_valid), .next_ready_i (next_ready),
    .opcode_i (opcode), .alu_op_i (alu_op), .op1_i (op1), .op2_i (op2), .opj_i (opj),
    .imm_i (imm), .pc_i (pc), .rd_i (rd), .rwen_i (rwen), .ready_o (ready),
    .valid_o (valid), .reg_wdata_o (reg_wdata), .npc_o (npc), .rd_o (rd_out),
    .rwen_o (rwen_out), .wben_o (wben), .ebreak_o (ebreak)
  );

  // Each instruction gets 40 cycles, plus a margin for reset.
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 40 * issued + 100) begin
      $display("timeout: the run stalled after %0d cycles with %0d errors", cycles, errors);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t alu_model(input alu_op_t kind, input word_t a, input word_t b);
    int    sh;
    word_t fill;
    logic  lt_s;
    sh   = int'(b[4:0]);
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;  // Sign bits shifted in by sra.
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (kind)
      `ALU_ADD:  return a + b;
      `ALU_SUB:  return a + ~b + 32'd1;
      `ALU_AND:  return a & b;
      `ALU_OR:   return a | b;
      `ALU_XOR:  return a ^ b;
      `ALU_SLL:  return a << sh;
      `ALU_SRL:  return a >> sh;
      `ALU_SRA:  return (a >> sh) | fill;
      `ALU_SLT:  return {31'd0, lt_s};
      `ALU_SLTU: return {31'd0, a < b};
      `ALU_SGE:  return {31'd0, !lt_s};
      `ALU_SGEU: return {31'd0, a >= b};
      default:   return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(input alu_op_t kind, input word_t a, input word_t b);
    case (kind)
      `ALU_SUB: return a == b;
      `ALU_XOR: return a != b;
      default:  return alu_model(kind, a, b) == 32'd1;
    endcase
  endfunction

  function automatic word_t csr_model_read(input csr_addr_t addr);
    case (addr)
      `CSR_MSTATUS: return m_mstatus;
      `CSR_MTVEC:   return m_mtvec;
      `CSR_MEPC:    return m_mepc;
      `CSR_MCAUSE:  return m_mcause;
      default:      return 32'd0;
    endcase
  endfunction

  task automatic report_mismatch(input string what, input word_t got, input word_t exp);
    errors++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // Issues one instruction, holds the result for a number of stall cycles and commits it.
  task automatic issue(input opcode_t code, input alu_op_t aop, input word_t src1,
                       input word_t src2, input word_t base, input word_t offs,
                       input word_t pc_val, input int stall);
    int       n_stall;
    word_t    snap_wdata;
    word_t    snap_npc;
    logic     snap_ebreak;
    reg_idx_t snap_rd;
    issued++;
    cur_rd = reg_idx_t'(issued);
    cur_rwen = issued[0];
    opcode = code;
    alu_op = aop;
    op1 = src1;
    op2 = src2;
    opj = base;
    imm = offs;
    pc = pc_val;
    rd = cur_rd;
    rwen = cur_rwen;
    prev_valid = 1'b1;
    while (!ready) step();
    step();
    prev_valid = 1'b0;
    res_lat = 0;
    while (!valid) begin
      step();
      res_lat++;
    end
    if (wben !== 1'b1) report_mismatch("wben_o at first valid cycle", word_t'(wben), 32'd1);
    n_stall = (stall >= 0) ? stall : int'(next_rand() % 4);
    snap_wdata = reg_wdata;
    snap_npc = npc;
    snap_ebreak = ebreak;
    snap_rd = rd_out;
    for (int i = 0; i < n_stall; i++) begin
      step();
      if (valid !== 1'b1) report_mismatch("valid_o under stall", word_t'(valid), 32'd1);
      if (wben !== 1'b0) report_mismatch("wben_o under stall", word_t'(wben), 32'd0);
      if (ready !== 1'b0) report_mismatch("ready_o under stall", word_t'(ready), 32'd0);
      if (reg_wdata !== snap_wdata) report_mismatch("reg_wdata_o stall", reg_wdata, snap_wdata);
      if (npc !== snap_npc) report_mismatch("npc_o under stall", npc, snap_npc);
      if (ebreak !== snap_ebreak) begin
        report_mismatch("ebreak_o under stall", word_t'(ebreak), word_t'(snap_ebreak));
      end
      if (rd_out !== snap_rd) begin
        report_mismatch("rd_o under stall", word_t'(rd_out), word_t'(snap_rd));
      end
    end
    res_wdata = reg_wdata;
    res_npc = npc;
    res_ebreak = ebreak;
    res_rd = rd_out;
    res_rwen = rwen_out;
    next_ready = 1'b1;
    step();
    next_ready = 1'b0;
    if (valid !== 1'b0) report_mismatch("valid_o after commit", word_t'(valid), 32'd0);
  endtask

  task automatic test_alu();
    alu_op_t ops [12];
    word_t   a;
    word_t   b;
    word_t   pcv;
    word_t   exp;
    ops = '{`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_XOR, `ALU_SLL,
            `ALU_SRL, `ALU_SRA, `ALU_SLT, `ALU_SLTU, `ALU_SGE, `ALU_SGEU};
    for (int k = 0; k < 12; k++) begin
      a = next_rand();
      b = next_rand();
      pcv = next_rand() & 32'h0000_fffc;
      exp = alu_model(ops[k], a, b);
      issue(`OP_ALU, ops[k], a, b, 32'd0, 32'd0, pcv, -1);
      if (res_wdata !== exp) report_mismatch("alu result", res_wdata, exp);
      if (res_npc !== pcv + 32'd4) report_mismatch("alu npc", res_npc, pcv + 32'd4);
      if (res_rd !== cur_rd) report_mismatch("rd_o", word_t'(res_rd), word_t'(cur_rd));
      if (res_rwen !== cur_rwen) report_mismatch("rwen_o", word_t'(res_rwen), word_t'(cur_rwen));
      if (res_ebreak !== 1'b0) report_mismatch("ebreak_o on alu", word_t'(res_ebreak), 32'd0);
    end
  endtask

  task automatic test_branch();
    alu_op_t kinds [6];
    word_t   xs [3];
    word_t   ys [3];
    word_t   pcv;
    word_t   off;
    word_t   exp;
    kinds = '{`ALU_SUB, `ALU_XOR, `ALU_SLT, `ALU_SLTU, `ALU_SGE, `ALU_SGEU};
    xs = '{32'hffff_fffb, 32'hffff_fffb, 32'h0000_0003};  // -5 is below 3 signed only.
    ys = '{32'hffff_fffb, 32'h0000_0003, 32'hffff_fffb};
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        pcv = next_rand() & 32'h0000_fffc;
        off = next_rand() & 32'h0000_0ffc;
        exp = branch_taken(kinds[k], xs[p], ys[p]) ? pcv + off : pcv + 32'd4;
        issue(`OP_BRANCH, kinds[k], xs[p], ys[p], pcv, off, pcv, -1);
        if (res_npc !== exp) report_mismatch("branch npc", res_npc, exp);
      end
    end
  endtask

  task automatic test_jump();
    opcode_t codes [2];
    word_t   pcv;
    word_t   off;
    word_t   base;
    codes = '{`OP_JAL, `OP_JALR};
    for (int k = 0; k < 2; k++) begin
      pcv = next_rand() & 32'h0000_fffc;
      off = next_rand() & 32'h0000_0ffc;
      base = (k == 0) ? pcv : (next_rand() & 32'h0000_fffc);
      issue(codes[k], `ALU_ADD, base, 32'd0, base, off, pcv, -1);
      if (res_npc !== base + off) report_mismatch("jump npc", res_npc, base + off);
      if (res_wdata !== pcv + 32'd4) report_mismatch("jump link", res_wdata, pcv + 32'd4);
    end
  endtask

  task automatic test_mem();
    word_t addrs [5];
    word_t data;
    word_t exp;
    addrs = '{32'h000, 32'h004, 32'h180, 32'h3fc, 32'h200};  // The last one is never stored.
    for (int i = 0; i < 4; i++) begin
      data = next_rand();
      issue(`OP_STORE, `ALU_ADD, 32'd0, data, addrs[i] - 32'h10, 32'h10, 32'h800, -1);
      model_mem[addrs[i][9:2]] = data;
      if (res_npc !== 32'h804) report_mismatch("store npc", res_npc, 32'h804);
    end
    for (int i = 4; i >= 0; i--) begin
      exp = model_mem[addrs[i][9:2]];
      issue(`OP_LOAD, `ALU_ADD, 32'd0, 32'd0, addrs[i], 32'd0, 32'h900, -1);
      if (res_wdata !== exp) report_mismatch("load data", res_wdata, exp);
      if (res_lat < `MEM_LATENCY + 2) begin
        report_failure($sformatf("load finished only %0d cycles after acceptance", res_lat));
      end
    end
  endtask

  task automatic csr_op(input logic [3:0] f3, input csr_addr_t addr, input word_t src);
    word_t old;
    word_t s;
    word_t nv;
    word_t pcv;
    old = csr_model_read(addr);
    s = src;
    if (f3 == `F3_CSRRWI || f3 == `F3_CSRRSI || f3 == `F3_CSRRCI) begin
      s = {27'd0, src[4:0]};
    end
    case (f3)
      `F3_CSRRS, `F3_CSRRSI: nv = old | s;
      `F3_CSRRC, `F3_CSRRCI: nv = old & ~s;
      default:               nv = s;
    endcase
    pcv = next_rand() & 32'h0000_fffc;
    issue(`OP_SYSTEM, `ALU_ADD, src, 32'd0, 32'd0, word_t'({addr, f3}), pcv, -1);
    if (res_wdata !== old) report_mismatch("csr old value", res_wdata, old);
    if (res_npc !== pcv + 32'd4) report_mismatch("csr npc", res_npc, pcv + 32'd4);
    case (addr)
      `CSR_MSTATUS: m_mstatus = nv;
      `CSR_MTVEC:   m_mtvec = nv;
      `CSR_MEPC:    m_mepc = nv;
      `CSR_MCAUSE:  m_mcause = nv;
      default: begin
      end
    endcase
  endtask

  task automatic test_csr();
    csr_op(`F3_CSRRW, `CSR_MTVEC, next_rand());
    csr_op(`F3_CSRRS, `CSR_MTVEC, next_rand());
    csr_op(`F3_CSRRC, `CSR_MTVEC, next_rand());
    csr_op(`F3_CSRRWI, `CSR_MSTATUS, next_rand());
    csr_op(`F3_CSRRSI, `CSR_MSTATUS, 32'h0000_0018);
    csr_op(`F3_CSRRCI, `CSR_MSTATUS, 32'h0000_0008);
    csr_op(`F3_CSRRW, `CSR_MSTATUS, next_rand());
    csr_op(`F3_CSRRS, `CSR_MSTATUS, 32'd0);
    csr_op(`F3_CSRRS, `CSR_MTVEC, 32'd0);
  endtask

  task automatic test_trap();
    word_t pcv;
    csr_op(`F3_CSRRW, `CSR_MTVEC, 32'h0000_0400);
    pcv = 32'h0000_0120;
    issue(`OP_SYSTEM, `ALU_ADD, 32'd0, 32'd0, 32'd0, word_t'({`F12_ECALL, `F3_PRIV}), pcv, -1);
    if (res_npc !== m_mtvec) report_mismatch("ecall npc", res_npc, m_mtvec);
    m_mepc = pcv;
    m_mcause = 32'd11;  // Environment call from machine mode.
    csr_op(`F3_CSRRS, `CSR_MEPC, 32'd0);
    csr_op(`F3_CSRRS, `CSR_MCAUSE, 32'd0);
    csr_op(`F3_CSRRW, `CSR_MSTATUS, 32'h0000_0080);
    issue(`OP_SYSTEM, `ALU_ADD, 32'd0, 32'd0, 32'd0, word_t'({`F12_MRET, `F3_PRIV}), 32'h200, -1);
    if (res_npc !== m_mepc) report_mismatch("mret npc", res_npc, m_mepc);
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
    csr_op(`F3_CSRRS, `CSR_MSTATUS, 32'd0);
  endtask

  task automatic test_ebreak();
    issue(`OP_SYSTEM, `ALU_ADD, 32'd0, 32'd0, 32'd0, word_t'({`F12_EBREAK, `F3_PRIV}),
          32'h300, 3);
    if (res_ebreak !== 1'b1) report_mismatch("ebreak_o with valid", word_t'(res_ebreak), 32'd1);
    if (ebreak !== 1'b0) report_mismatch("ebreak_o after commit", word_t'(ebreak), 32'd0);
  endtask

  initial begin
    prev_valid = 1'b0;
    next_ready = 1'b0;
    opcode = '0;
    alu_op = '0;
    op1 = '0;
    op2 = '0;
    opj = '0;
    imm = '0;
    pc = '0;
    rd = '0;
    rwen = 1'b0;
    errors = 0;
    issued = 0;
    cycles = 0;
    rng = 32'h81a3;
    m_mstatus = '0;
    m_mtvec = '0;
    m_mepc = '0;
    m_mcause = '0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    step();
    while (rst) step();
    if (valid !== 1'b0) report_mismatch("valid_o after reset", word_t'(valid), 32'd0);
    if (wben !== 1'b0) report_mismatch("wben_o after reset", word_t'(wben), 32'd0);
    if (ready !== 1'b1) report_mismatch("ready_o after reset", word_t'(ready), 32'd1);
    if (ebreak !== 1'b0) report_mismatch("ebreak_o after reset", word_t'(ebreak), 32'd0);
    test_alu();
    test_branch();
    test_jump();
    test_mem();
    test_csr();
    test_trap();
    test_ebreak();
    $display("%0d errors in %0d instructions", errors, issued);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end
endmodule

// File: exec_unit.f
+incdir+design
design/exec_pkg.sv
design/mem_bus_if.sv
design/alu.sv
design/csr_file.sv
design/data_mem.sv
design/exu.sv
design/exec_top.sv
bench/tb_clock.sv
bench/exec_tb.sv

// File: run.sh
#!/bin/sh
# Builds the execute-stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f exec_unit.f --top-module exec_tb -o exec_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0
